/* design/stack_cfg_pkg.sv */
/*
 * default sizing of the dual-issue stack
 * data width and log2 of the number of entries
 */
package stack_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // default geometry
  ////////////////////////////////////////////////////////////

  // one stack word, same width as the processor data path
  localparam int DATA_W_DEF = 32;

  // log2 of the entry count, 10 gives 1024 entries
  // the item count carries one more bit than this so a full stack fits
  localparam int DEPTH_LOG2_DEF = 10;

endpackage

/* design/stack_op_pkg.sv */
/*
 * per-slot stack opcode and the source select of a delayed pop result
 */
package stack_op_pkg;

  // opcode issued by one pipeline slot each cycle
  // code 2'b11 is unused and decodes as op_none
  typedef enum logic [1:0] {
    op_none = 2'b00,
    op_push = 2'b01,
    op_pop  = 2'b10
  } slot_op_e;

  // where a slot result comes from in the cycle after its pop
  typedef enum logic [1:0] {
    src_ram_a  = 2'b00,  // registered read data of port a
    src_ram_b  = 2'b01,  // registered read data of port b
    src_bypass = 2'b10,  // slot 0 push word forwarded to slot 1
    src_zero   = 2'b11   // pop on empty returns zero
  } res_src_e;

endpackage

/* design/stack_mem_if.sv */
/*
 * both ports of the stack memory between controller and RAM
 * ctrl and mem modports
 */
interface stack_mem_if #(
  parameter int DATA_W     = stack_cfg_pkg::DATA_W_DEF,
  parameter int DEPTH_LOG2 = stack_cfg_pkg::DEPTH_LOG2_DEF
);

  // port a serves slot 0, port b the second access of the pair
  logic [DEPTH_LOG2-1:0] addr_a;
  logic [DEPTH_LOG2-1:0] addr_b;
  logic [DATA_W-1:0]     wdata_a;
  logic [DATA_W-1:0]     wdata_b;
  logic                  we_a;
  logic                  we_b;
  logic [DATA_W-1:0]     rdata_a;  // valid one cycle after the address
  logic [DATA_W-1:0]     rdata_b;

  // controller side drives addresses, data and enables
  modport ctrl (output addr_a, addr_b, wdata_a, wdata_b, we_a, we_b,
                input  rdata_a, rdata_b);

  // memory side returns the read words
  modport mem  (input  addr_a, addr_b, wdata_a, wdata_b, we_a, we_b,
                output rdata_a, rdata_b);

endinterface

/* design/stack_ram.sv */
/*
 * inferred two-port RAM for the stack storage
 * read-first on both ports, registered read data
 */
module stack_ram #(
  parameter int DATA_W     = stack_cfg_pkg::DATA_W_DEF,
  parameter int DEPTH_LOG2 = stack_cfg_pkg::DEPTH_LOG2_DEF
) (
  input logic     clk,
  stack_mem_if.mem mem
);

  localparam int DEPTH = 2 ** DEPTH_LOG2;

  logic [DATA_W-1:0] store [DEPTH];  // stack entries, bottom item at index 0

  ////////////////////////////////////////////////////////////
  // both ports
  ////////////////////////////////////////////////////////////

  // one process owns the array so the write order between the ports is fixed
  // the controller never issues two writes to one address
  always_ff @(posedge clk) begin
    if (mem.we_a) begin
      store[mem.addr_a] <= mem.wdata_a;
    end
    if (mem.we_b) begin
      store[mem.addr_b] <= mem.wdata_b;  // comes last so port b wins a collision
    end
    mem.rdata_a <= store[mem.addr_a];  // old contents come out on a write
    mem.rdata_b <= store[mem.addr_b];  // read-first as on port a
  end

endmodule

/* design/stack_ctrl.sv */
/*
 * stack pointer and pair decode for two issue slots
 * memory port address and write enable generation
 * push0/pop1 bypass and delayed result select
 */
module stack_ctrl #(
  parameter int DATA_W     = stack_cfg_pkg::DATA_W_DEF,
  parameter int DEPTH_LOG2 = stack_cfg_pkg::DEPTH_LOG2_DEF
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  stack_op_pkg::slot_op_e  op0,
  input  stack_op_pkg::slot_op_e  op1,
  input  logic [DATA_W-1:0]       wdata0,
  input  logic [DATA_W-1:0]       wdata1,
  input  logic [DEPTH_LOG2:0]     limit,    // software full point
  stack_mem_if.ctrl               mem,
  output logic [DATA_W-1:0]       result0,
  output logic [DATA_W-1:0]       result1,
  output logic                    valid0,
  output logic                    valid1,
  output logic [DEPTH_LOG2:0]     depth,
  output logic                    ovf_evt,  // one-cycle pulse on a dropped push
  output logic                    unf_evt   // one-cycle pulse on a pop at empty
);

  import stack_op_pkg::*;

  localparam int CNT_W = DEPTH_LOG2 + 1;

  logic [CNT_W-1:0] count, count_d;  // items on the stack, top item at count-1
  logic [CNT_W-1:0] cnt_p1, cnt_m1, cnt_m2, free;
  logic [1:0]       n_push, n_pop;
  logic             push0, pop0, push1, pop1;
  logic             full, empty;
  res_src_e         src0_d, src1_d, src0_q, src1_q;
  logic [DATA_W-1:0] byp_q;            // slot 0 push word held for the bypass

  // 2'b11 matches neither compare and acts as op_none
  assign push0 = (op0 == op_push);
  assign pop0  = (op0 == op_pop);
  assign push1 = (op1 == op_push);
  assign pop1  = (op1 == op_pop);

  assign full   = (count >= limit);  // a lowered limit can sit below count
  assign empty  = (count == '0);
  assign free   = full ? '0 : limit - count;
  assign cnt_p1 = count + CNT_W'(1);
  assign cnt_m1 = count - CNT_W'(1);
  assign cnt_m2 = count - CNT_W'(2);

  // write data never changes slot, only the address moves
  assign mem.wdata_a = wdata0;
  assign mem.wdata_b = wdata1;

  ////////////////////////////////////////////////////////////
  // pair decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    mem.addr_a = cnt_m1[DEPTH_LOG2-1:0];
    mem.addr_b = cnt_m1[DEPTH_LOG2-1:0];
    mem.we_a   = 1'b0;
    mem.we_b   = 1'b0;
    n_push     = 2'd0;
    n_pop      = 2'd0;
    ovf_evt    = 1'b0;
    unf_evt    = 1'b0;
    src0_d     = src_zero;
    src1_d     = src_zero;
    if (push0 && push1) begin
      // slot 0 lands at count, slot 1 above it if a second entry is free
      mem.addr_a = count[DEPTH_LOG2-1:0];
      mem.addr_b = cnt_p1[DEPTH_LOG2-1:0];
      mem.we_a   = !full;
      mem.we_b   = (free >= CNT_W'(2));
      n_push     = {1'b0, mem.we_a} + {1'b0, mem.we_b};
      ovf_evt    = !mem.we_b;
    end else if (pop0 && pop1) begin
      mem.addr_b = cnt_m2[DEPTH_LOG2-1:0];  // slot 1 takes the item below the top
      src0_d     = empty ? src_zero : src_ram_a;
      src1_d     = (count >= CNT_W'(2)) ? src_ram_b : src_zero;
      n_pop      = empty ? 2'd0 : (count == CNT_W'(1)) ? 2'd1 : 2'd2;
      unf_evt    = (count < CNT_W'(2));
    end else if (push0 && pop1) begin
      src1_d = src_bypass;  // stack untouched, the pair cancels out
    end else if (pop0 && push1) begin
      if (empty) begin
        // nothing to replace so slot 1 becomes a plain push
        unf_evt    = 1'b1;
        mem.addr_b = count[DEPTH_LOG2-1:0];
        mem.we_b   = !full;
        n_push     = {1'b0, !full};
        ovf_evt    = full;
      end else begin
        mem.we_b = 1'b1;  // port a reads the top while port b overwrites it
        src0_d   = src_ram_a;
      end
    end else begin
      // at most one slot is active here
      if (push0) begin
        mem.addr_a = count[DEPTH_LOG2-1:0];
        mem.we_a   = !full;
        n_push     = {1'b0, !full};
        ovf_evt    = full;
      end else if (pop0) begin
        src0_d  = empty ? src_zero : src_ram_a;
        n_pop   = {1'b0, !empty};
        unf_evt = empty;
      end
      if (push1) begin
        mem.addr_b = count[DEPTH_LOG2-1:0];
        mem.we_b   = !full;
        n_push     = {1'b0, !full};
        ovf_evt    = full;
      end else if (pop1) begin
        src1_d  = empty ? src_zero : src_ram_b;
        n_pop   = {1'b0, !empty};
        unf_evt = empty;
      end
    end
  end

  assign count_d = count + CNT_W'(n_push) - CNT_W'(n_pop);

  ////////////////////////////////////////////////////////////
  // state and result select
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count  <= '0;
      valid0 <= 1'b0;
      valid1 <= 1'b0;
      src0_q <= src_zero;
      src1_q <= src_zero;
    end else begin
      count  <= count_d;
      valid0 <= pop0;  // every pop returns something, even on empty
      valid1 <= pop1;
      src0_q <= src0_d;
      src1_q <= src1_d;
    end
  end

  always_ff @(posedge clk) begin
    if (push0 && pop1) begin
      byp_q <= wdata0;
    end
  end

  // both slots share one mux over the RAM words, the bypass word and zero
  function automatic logic [DATA_W-1:0] pick(input res_src_e src,
                                             input logic [DATA_W-1:0] ra,
                                             input logic [DATA_W-1:0] rb,
                                             input logic [DATA_W-1:0] byp);
    case (src)
      src_ram_a:  return ra;
      src_ram_b:  return rb;
      src_bypass: return byp;
      default:    return '0;
    endcase
  endfunction

  assign result0 = pick(src0_q, mem.rdata_a, mem.rdata_b, byp_q);
  assign result1 = pick(src1_q, mem.rdata_a, mem.rdata_b, byp_q);
  assign depth   = count;

endmodule

/* design/stack_status.sv */
/*
 * depth limit register and sticky overflow and underflow flags
 */
module stack_status #(
  parameter int DEPTH_LOG2 = stack_cfg_pkg::DEPTH_LOG2_DEF
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cfg_we,     // load cfg_limit this cycle
  input  logic [DEPTH_LOG2:0]   cfg_limit,
  input  logic                  err_clr,    // clears both sticky flags
  input  logic                  ovf_evt,
  input  logic                  unf_evt,
  output logic [DEPTH_LOG2:0]   limit,
  output logic                  overflow,
  output logic                  underflow
);

  localparam int             CNT_W = DEPTH_LOG2 + 1;
  localparam logic [CNT_W-1:0] CAP = CNT_W'(2 ** DEPTH_LOG2);  // physical entries

  ////////////////////////////////////////////////////////////
  // depth limit
  ////////////////////////////////////////////////////////////

  // a value above the RAM size is clamped so full still fires at capacity
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      limit <= CAP;
    end else if (cfg_we) begin
      limit <= (cfg_limit > CAP) ? CAP : cfg_limit;
    end
  end

  ////////////////////////////////////////////////////////////
  // sticky error flags
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      overflow  <= 1'b0;
      underflow <= 1'b0;
    end else begin
      overflow  <= ovf_evt | (overflow & !err_clr);   // new event beats the clear
      underflow <= unf_evt | (underflow & !err_clr);
    end
  end

endmodule

/* design/dual_stack.sv */
/*
 * dual-issue stack unit top level
 * controller, status block and two-port RAM
 */
module dual_stack #(
  parameter int DATA_W     = stack_cfg_pkg::DATA_W_DEF,
  parameter int DEPTH_LOG2 = stack_cfg_pkg::DEPTH_LOG2_DEF
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  stack_op_pkg::slot_op_e  op0,        // older slot, applied first
  input  stack_op_pkg::slot_op_e  op1,
  input  logic [DATA_W-1:0]       wdata0,
  input  logic [DATA_W-1:0]       wdata1,
  input  logic                    cfg_we,
  input  logic [DEPTH_LOG2:0]     cfg_limit,
  input  logic                    err_clr,
  output logic [DATA_W-1:0]       result0,    // one cycle after a slot 0 pop
  output logic [DATA_W-1:0]       result1,
  output logic                    valid0,
  output logic                    valid1,
  output logic [DEPTH_LOG2:0]     depth,
  output logic                    overflow,
  output logic                    underflow
);

  logic [DEPTH_LOG2:0] limit;
  logic                ovf_evt, unf_evt;

  stack_mem_if #(.DATA_W(DATA_W), .DEPTH_LOG2(DEPTH_LOG2)) mem_if ();

  // pair decode, pointer and result select
  stack_ctrl #(.DATA_W(DATA_W), .DEPTH_LOG2(DEPTH_LOG2)) ctrl_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .op0     (op0),
    .op1     (op1),
    .wdata0  (wdata0),
    .wdata1  (wdata1),
    .limit   (limit),
    .mem     (mem_if.ctrl),
    .result0 (result0),
    .result1 (result1),
    .valid0  (valid0),
    .valid1  (valid1),
    .depth   (depth),
    .ovf_evt (ovf_evt),
    .unf_evt (unf_evt)
  );

  stack_status #(.DEPTH_LOG2(DEPTH_LOG2)) status_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg_we    (cfg_we),
    .cfg_limit (cfg_limit),
    .err_clr   (err_clr),
    .ovf_evt   (ovf_evt),
    .unf_evt   (unf_evt),
    .limit     (limit),
    .overflow  (overflow),
    .underflow (underflow)
  );

  stack_ram #(.DATA_W(DATA_W), .DEPTH_LOG2(DEPTH_LOG2)) ram_i (
    .clk (clk),
    .mem (mem_if.mem)
  );

endmodule

/* tests/dual_stack_checker.sv */
/*
 * concurrent assertions on the stack controller
 * bound into stack_ctrl from the testbench
 */
module dual_stack_checker #(
  parameter int DEPTH_LOG2 = stack_cfg_pkg::DEPTH_LOG2_DEF
) (
  input logic                  clk,
  input logic                  rst_n,
  input logic [DEPTH_LOG2:0]   depth,
  input logic                  we_a,
  input logic                  we_b,
  input logic [DEPTH_LOG2-1:0] addr_a,
  input logic [DEPTH_LOG2-1:0] addr_b,
  input logic                  valid0,
  input logic                  valid1
);

  localparam int CAP = 2 ** DEPTH_LOG2;

  depth_in_range: assert property (@(posedge clk) disable iff (!rst_n) depth <= CAP)
    else $error("depth %0d above capacity", depth);

  // two pushes or two pops move the pointer by two at most
  depth_step: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> (depth <= $past(depth) + 2) && ($past(depth) <= depth + 2))
    else $error("depth jumped by more than two");

  no_write_clash: assert property (@(posedge clk) disable iff (!rst_n)
    !(we_a && we_b && addr_a == addr_b))
    else $error("both ports write address %0d", addr_a);

  valid_after_reset: assert property (@(posedge clk) !rst_n |=> !valid0 && !valid1)
    else $error("valid strobe high right after reset");

endmodule

/* tests/dual_stack_tb.sv */
/*
 * testbench for the dual-issue stack unit
 * clock, reset, directed and seeded random opcode pairs
 * queue based reference model, per-cycle output checks and report
 */
module dual_stack_tb;

  import stack_cfg_pkg::*;
  import stack_op_pkg::*;

  localparam int DATA_W     = DATA_W_DEF;
  localparam int DEPTH_LOG2 = 4;              // 16 entries so full comes up often
  localparam int CAP        = 2 ** DEPTH_LOG2;
  localparam int RST_LEN    = 2;
  localparam int T1_LEN     = 16;             // cycles used by each directed test
  localparam int T2_LEN     = 11;
  localparam int T3_LEN     = 13;
  localparam int T4_LEN     = 12;
  localparam int T5_LEN     = 14;
  localparam int RAND_LEN   = 2000;
  localparam int MAX_CYC    = RST_LEN + T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN
                              + RAND_LEN + 50;

  logic                clk, rst_n;
  slot_op_e            op0, op1;
  logic [DATA_W-1:0]   wdata0, wdata1, result0, result1;
  logic                cfg_we, err_clr, valid0, valid1, overflow, underflow;
  logic [DEPTH_LOG2:0] cfg_limit, depth;

  // reference model state, the queue tail is the top of the stack
  logic [DATA_W-1:0] mq[$];
  int                m_limit;
  bit                m_ovf, m_unf;
  bit                e_v0, e_v1;              // expected strobes after the next edge
  logic [DATA_W-1:0] e_r0, e_r1;

  integer      seed;
  logic [31:0] rnd;
  int          errors, checks, tests_run, err_at_start, cycle_cnt;
  string       cur_name;

  dual_stack #(.DATA_W(DATA_W), .DEPTH_LOG2(DEPTH_LOG2)) dut_i (
    .clk (clk), .rst_n (rst_n), .op0 (op0), .op1 (op1),
    .wdata0 (wdata0), .wdata1 (wdata1), .cfg_we (cfg_we), .cfg_limit (cfg_limit),
    .err_clr (err_clr), .result0 (result0), .result1 (result1), .valid0 (valid0),
    .valid1 (valid1), .depth (depth), .overflow (overflow), .underflow (underflow)
  );

  bind stack_ctrl dual_stack_checker #(.DEPTH_LOG2(DEPTH_LOG2)) checker_i (
    .clk (clk), .rst_n (rst_n), .depth (depth), .we_a (mem.we_a), .we_b (mem.we_b),
    .addr_a (mem.addr_a), .addr_b (mem.addr_b), .valid0 (valid0), .valid1 (valid1)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // hard stop in case a test never returns
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > MAX_CYC) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYC);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  // one slot applied on its own against the current model stack
  task automatic apply_slot(input bit push, input bit pop, input logic [DATA_W-1:0] w,
                            output logic [DATA_W-1:0] res, inout bit ovf, inout bit unf);
    res = '0;                                  // a pop on empty returns zero
    if (push) begin
      if (mq.size() >= m_limit) ovf = 1'b1;    // full, the word is dropped
      else mq.push_back(w);
    end else if (pop) begin
      if (mq.size() == 0) unf = 1'b1;
      else res = mq.pop_back();
    end
  endtask

  task automatic model_step(input slot_op_e o0, input slot_op_e o1,
                            input logic [DATA_W-1:0] w0, input logic [DATA_W-1:0] w1,
                            input bit we, input int lim, input bit clr);
    bit ovf, unf;
    ovf  = 1'b0;
    unf  = 1'b0;
    e_v0 = (o0 == op_pop);                     // the unused code counts as none
    e_v1 = (o1 == op_pop);
    e_r0 = '0;
    e_r1 = '0;
    if (o0 == op_push && o1 == op_pop) begin
      e_r1 = w0;                               // forwarded, stack left alone
    end else if (o0 == op_pop && o1 == op_push && mq.size() > 0) begin
      e_r0 = mq[mq.size()-1];                  // old top out, new word in its place
      mq[mq.size()-1] = w1;
    end else begin
      apply_slot(o0 == op_push, o0 == op_pop, w0, e_r0, ovf, unf);
      apply_slot(o1 == op_push, o1 == op_pop, w1, e_r1, ovf, unf);
    end
    m_ovf = ovf | (m_ovf & !clr);              // an event in the clear cycle still sets
    m_unf = unf | (m_unf & !clr);
    if (we) m_limit = (lim > CAP) ? CAP : lim; // used from the next cycle on
  endtask

  ////////////////////////////////////////////////////////////
  // checks and cycle driver
  ////////////////////////////////////////////////////////////

  task automatic compare(input string name, input logic [DATA_W-1:0] exp,
                         input logic [DATA_W-1:0] got);
    checks++;
    assert (got === exp) else begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_outputs();
    compare("valid0", e_v0, valid0);
    compare("valid1", e_v1, valid1);
    if (e_v0) compare("result0", e_r0, result0);  // result is only defined with valid
    if (e_v1) compare("result1", e_r1, result1);
    compare("depth", mq.size(), depth);
    compare("overflow", m_ovf, overflow);
    compare("underflow", m_unf, underflow);
  endtask

  // drive one opcode pair 2 units after the edge, check just after the next edge
  task automatic step_cycle(input slot_op_e o0, input slot_op_e o1,
                            input bit we = 1'b0, input int lim = 0, input bit clr = 1'b0);
    logic [DATA_W-1:0] w0, w1;
    w0        = $random(seed);
    w1        = $random(seed);
    op0       = o0;
    op1       = o1;
    wdata0    = w0;
    wdata1    = w1;
    cfg_we    = we;
    cfg_limit = lim[DEPTH_LOG2:0];
    err_clr   = clr;
    model_step(o0, o1, w0, w1, we, lim, clr);
    @(posedge clk);
    #1;
    check_outputs();
    #1;
  endtask

  task automatic begin_test(input string name);
    cur_name     = name;
    err_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    $display("test %s finished with %0d errors", cur_name, errors - err_at_start);
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed      = 58;
    rst_n     = 1'b0;
    op0       = op_none;
    op1       = op_none;
    wdata0    = '0;
    wdata1    = '0;
    cfg_we    = 1'b0;
    cfg_limit = '0;
    err_clr   = 1'b0;
    m_limit   = CAP;
    m_ovf     = 1'b0;
    m_unf     = 1'b0;
    e_v0      = 1'b0;
    e_v1      = 1'b0;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    cycle_cnt = 0;
    repeat (RST_LEN) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_outputs();                           // reset state, empty and no flags

    begin_test("lifo_bursts");
    repeat (4) step_cycle(op_push, op_push);
    repeat (2) step_cycle(op_push, op_none);
    repeat (2) step_cycle(op_none, op_push);
    repeat (4) step_cycle(op_pop, op_pop);
    repeat (2) step_cycle(op_pop, op_none);
    repeat (2) step_cycle(op_none, op_pop);
    end_test();

    begin_test("mixed_pairs");
    repeat (3) step_cycle(op_push, op_none);
    repeat (2) step_cycle(op_push, op_pop);
    repeat (2) step_cycle(op_pop, op_push);    // second one returns the first one's word
    repeat (3) step_cycle(op_pop, op_none);
    step_cycle(op_none, op_none);
    end_test();

    begin_test("fill_overflow");
    repeat (7) step_cycle(op_push, op_push);
    step_cycle(op_push, op_none);              // one entry left
    step_cycle(op_push, op_push);              // slot 1 is dropped
    repeat (2) step_cycle(op_none, op_none);   // flag holds
    step_cycle(op_none, op_none, 1'b0, 0, 1'b1);
    step_cycle(op_none, op_none);
    end_test();

    begin_test("drain_underflow");
    repeat (7) step_cycle(op_pop, op_pop);
    step_cycle(op_pop, op_none);
    step_cycle(op_pop, op_pop);                // one item, slot 1 gets zero
    step_cycle(op_none, op_none);
    step_cycle(op_none, op_none, 1'b0, 0, 1'b1);
    step_cycle(op_none, op_none);
    end_test();

    begin_test("depth_limit");
    step_cycle(op_none, op_none, 1'b1, 5);
    repeat (6) step_cycle(op_push, op_none);   // sixth push hits the limit
    step_cycle(op_push, op_push);
    repeat (5) step_cycle(op_pop, op_none);
    step_cycle(op_none, op_none, 1'b1, 31, 1'b1);  // clamps back to capacity
    end_test();

    begin_test("random_pairs");
    for (int i = 0; i < RAND_LEN; i++) begin
      rnd = $random(seed);
      step_cycle(slot_op_e'(rnd[1:0]), slot_op_e'(rnd[3:2]), rnd[8:4] == 5'd0,
                 int'(rnd[13:9]), rnd[18:15] == 4'd0);
    end
    end_test();

    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
design/stack_cfg_pkg.sv
design/stack_op_pkg.sv
design/stack_mem_if.sv
design/stack_ram.sv
design/stack_ctrl.sv
design/stack_status.sv
design/dual_stack.sv
tests/dual_stack_checker.sv
tests/dual_stack_tb.sv

/* Bender.yml */
package:
  name: dual_stack

sources:
  - design/stack_cfg_pkg.sv
  - design/stack_op_pkg.sv
  - design/stack_mem_if.sv
  - design/stack_ram.sv
  - design/stack_ctrl.sv
  - design/stack_status.sv
  - design/dual_stack.sv
  - target: test
    files:
      - tests/dual_stack_checker.sv
      - tests/dual_stack_tb.sv
